/* all.f */
common/pe_pkg.sv
au/adder_tree.sv
au/au_mux.sv
design/operand_ram.sv
design/pe_arbiter.sv
design/pe_lane.sv
design/pe_cluster.sv
dv/pe_cluster_tb.sv

/* au/adder_tree.sv */
// adder_tree: combinational reduction of an element array into one wider sum
`timescale 1ns/1ps

module adder_tree #(
    parameter type elem_t = logic signed [7:0],
    parameter type sum_t  = logic signed [15:0],
    parameter int  NUM    = 8
) (
    input  elem_t i_in [NUM],
    output sum_t  o_out
);

    sum_t acc;

    // the cast extends by the element's own signedness
    // so 1-bit flags zero-extend and products sign-extend
    always_comb begin
        acc = '0;
        for (int i = 0; i < NUM; i++) begin
            acc = acc + sum_t'(i_in[i]);
        end
    end

    assign o_out = acc;

endmodule

/* au/au_mux.sv */
// au_mux: mixed-precision dot product of one activation word with one weight word
`timescale 1ns/1ps

module au_mux (
    input  pe_pkg::au_ctl_t                   i_ctl,
    input  logic [pe_pkg::DWD-1:0]            i_ipix,
    input  logic [pe_pkg::DWD-1:0]            i_wpix,
    output logic signed [pe_pkg::ASUMDWD-1:0] o_sum
);
    import pe_pkg::*;

    // ==================================================
    // precision select
    // ==================================================
    // one-hot: [0] 1b, [1] 2b, [2] 4b, [3] 8b
    logic [3:0] prec_en;
    logic       a_sgn;
    logic       w_sgn;

    // gated copies of the words, one per precision path
    logic [DWD-1:0] act [4];
    logic [DWD-1:0] wgt [4];

    always_comb begin
        case (i_ctl.mode)
            XNOR,
            M1:      prec_en = 4'b0001;
            M2:      prec_en = 4'b0010;
            M4:      prec_en = 4'b0100;
            M8:      prec_en = 4'b1000;
            default: prec_en = 4'b0000;
        endcase
    end

    assign a_sgn = (i_ctl.i_num_t == SIGNED);
    assign w_sgn = (i_ctl.w_num_t == SIGNED);

    // idle paths see zero words and stay quiet
    always_comb begin
        for (int p = 0; p < 4; p++) begin
            act[p] = i_ipix & {DWD{prec_en[p]}};
            wgt[p] = i_wpix & {DWD{prec_en[p]}};
        end
    end

    // ==================================================
    // element products
    // ==================================================
    // extended elements carry one extra bit for the sign
    logic signed [2:0] ext2_a [DWD/2];
    logic signed [2:0] ext2_w [DWD/2];
    logic signed [4:0] ext4_a [DWD/4];
    logic signed [4:0] ext4_w [DWD/4];
    logic signed [8:0] ext8_a [DWD/8];
    logic signed [8:0] ext8_w [DWD/8];

    logic   m1 [DWD];
    prod2_t m2 [DWD/2];
    prod4_t m4 [DWD/4];
    prod8_t m8 [DWD/8];

    always_comb begin
        // binary mode compares bits, M1 ands them
        for (int i = 0; i < DWD; i++) begin
            if (i_ctl.mode == XNOR) begin
                m1[i] = act[0][i] ~^ wgt[0][i];
            end else begin
                m1[i] = act[0][i] & wgt[0][i];
            end
        end
        for (int i = 0; i < DWD/2; i++) begin
            ext2_a[i] = {a_sgn & act[1][2*i+1], act[1][2*i +: 2]};
            ext2_w[i] = {w_sgn & wgt[1][2*i+1], wgt[1][2*i +: 2]};
            m2[i]     = ext2_a[i] * ext2_w[i];
        end
        for (int i = 0; i < DWD/4; i++) begin
            ext4_a[i] = {a_sgn & act[2][4*i+3], act[2][4*i +: 4]};
            ext4_w[i] = {w_sgn & wgt[2][4*i+3], wgt[2][4*i +: 4]};
            m4[i]     = ext4_a[i] * ext4_w[i];
        end
        for (int i = 0; i < DWD/8; i++) begin
            ext8_a[i] = {a_sgn & act[3][8*i+7], act[3][8*i +: 8]};
            ext8_w[i] = {w_sgn & wgt[3][8*i+7], wgt[3][8*i +: 8]};
            m8[i]     = ext8_a[i] * ext8_w[i];
        end
    end

    // ==================================================
    // reduction
    // ==================================================
    sum1_t                     sum1;
    sum2_t                     sum2;
    sum4_t                     sum4;
    logic signed [ASUMDWD-1:0] sum8;

    adder_tree #(.elem_t(logic), .sum_t(sum1_t), .NUM(DWD)) u_tree1 (
        .i_in  (m1),
        .o_out (sum1)
    );

    adder_tree #(.elem_t(prod2_t), .sum_t(sum2_t), .NUM(DWD/2)) u_tree2 (
        .i_in  (m2),
        .o_out (sum2)
    );

    adder_tree #(.elem_t(prod4_t), .sum_t(sum4_t), .NUM(DWD/4)) u_tree4 (
        .i_in  (m4),
        .o_out (sum4)
    );

    adder_tree #(
        .elem_t (prod8_t),
        .sum_t  (logic signed [ASUMDWD-1:0]),
        .NUM    (DWD/8)
    ) u_tree8 (
        .i_in  (m8),
        .o_out (sum8)
    );

    // popcount, zero-extended to the output width
    logic signed [ASUMDWD-1:0] pop_s;

    assign pop_s = ASUMDWD'(sum1);

    always_comb begin
        case (i_ctl.mode)
            // matches count +1, mismatches -1
            XNOR:    o_sum = (pop_s <<< 1) - ASUMDWD'(DWD);
            M1:      o_sum = (i_ctl.i_num_t == i_ctl.w_num_t) ? pop_s : -pop_s;
            M2:      o_sum = sum2;
            M4:      o_sum = sum4;
            M8:      o_sum = sum8;
            default: o_sum = '0;
        endcase
    end

endmodule

/* common/pe_pkg.sv */
// pe_pkg: shared widths, control encodings and payload types for the MAC cluster
package pe_pkg;

    // ==================================================
    // widths
    // ==================================================
    // one operand word per activation and per weight
    localparam int DWD     = 16;
    // per-word sum out of the arithmetic unit, signed
    localparam int ASUMDWD = 18;
    localparam int ACCWD   = 32;
    // 64 operand words
    localparam int AWD     = 6;
    localparam int NLANE   = 2;
    // word count 1..64
    localparam int LENWD   = 7;

    // ==================================================
    // control encodings
    // ==================================================
    typedef enum logic [2:0] {
        XNOR,
        M1,
        M2,
        M4,
        M8
    } au_mode_e;

    typedef enum logic {
        UNSIGNED,
        SIGNED
    } num_type_e;

    typedef struct packed {
        au_mode_e  mode;
        num_type_e i_num_t;
        num_type_e w_num_t;
    } au_ctl_t;

    // one RAM word, activation in the upper half
    typedef struct packed {
        logic [DWD-1:0] ipix;
        logic [DWD-1:0] wpix;
    } operand_word_t;

    // ==================================================
    // arithmetic payloads
    // ==================================================
    // products of (p+1)-bit extended elements
    typedef logic signed [4:0]  prod2_t;
    typedef logic signed [8:0]  prod4_t;
    typedef logic signed [16:0] prod8_t;

    // adder tree results, sized to the worst case per mode
    typedef logic        [4:0]  sum1_t;
    typedef logic signed [7:0]  sum2_t;
    typedef logic signed [10:0] sum4_t;

    typedef logic signed [ACCWD-1:0] acc_t;

    typedef struct packed {
        logic [AWD-1:0]   base;
        logic [LENWD-1:0] len;
        au_ctl_t          ctl;
    } job_t;

endpackage

/* design/operand_ram.sv */
// operand_ram: operand word memory, one write port and one registered read port
`timescale 1ns/1ps

module operand_ram (
    input  logic                   i_clk,
    input  logic                   i_arst_n,
    input  logic                   i_wr_en,
    input  logic [pe_pkg::AWD-1:0] i_wr_addr,
    input  pe_pkg::operand_word_t  i_wr_data,
    input  logic                   i_rd_en,
    input  logic [pe_pkg::AWD-1:0] i_rd_addr,
    output pe_pkg::operand_word_t  o_rd_data
);
    import pe_pkg::*;

    operand_word_t mem [2**AWD];
    operand_word_t rd_q;

    // write lands at the edge, readable the cycle after
    always_ff @(posedge i_clk) begin
        if (i_wr_en) begin
            mem[i_wr_addr] <= i_wr_data;
        end
    end

    // read data valid one cycle after the enable
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            rd_q <= '0;
        end else if (i_rd_en) begin
            rd_q <= mem[i_rd_addr];
        end
    end

    assign o_rd_data = rd_q;

endmodule

/* design/pe_arbiter.sv */
// pe_arbiter: round-robin sharing of the single RAM read port among the lanes
`timescale 1ns/1ps

module pe_arbiter (
    input  logic                     i_clk,
    input  logic                     i_arst_n,
    input  logic [pe_pkg::NLANE-1:0] i_req,
    input  logic [pe_pkg::AWD-1:0]   i_addr [pe_pkg::NLANE],
    output logic [pe_pkg::NLANE-1:0] o_gnt,
    output logic                     o_rd_en,
    output logic [pe_pkg::AWD-1:0]   o_rd_addr
);
    import pe_pkg::*;

    localparam int IW = (NLANE > 1) ? $clog2(NLANE) : 1;

    // lane granted most recently
    logic [IW-1:0] last_q;
    logic [IW-1:0] win;
    logic          found;
    int            idx;

    // search starts one past the last winner
    always_comb begin
        o_gnt = '0;
        win   = last_q;
        found = 1'b0;
        idx   = 0;
        for (int k = 1; k <= NLANE; k++) begin
            idx = (int'(last_q) + k) % NLANE;
            if (!found && i_req[idx]) begin
                o_gnt[idx] = 1'b1;
                win        = IW'(idx);
                found      = 1'b1;
            end
        end
    end

    assign o_rd_en   = found;
    assign o_rd_addr = i_addr[win];

    // reset points at the top lane so lane 0 wins first
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            last_q <= IW'(NLANE - 1);
        end else if (found) begin
            last_q <= win;
        end
    end

endmodule

/* design/pe_cluster.sv */
// pe_cluster: shared operand RAM, read arbiter and compute lanes
`timescale 1ns/1ps

module pe_cluster (
    input  logic                     i_clk,
    input  logic                     i_arst_n,
    input  logic                     i_wr_en,
    input  logic [pe_pkg::AWD-1:0]   i_wr_addr,
    input  pe_pkg::operand_word_t    i_wr_data,
    input  logic [pe_pkg::NLANE-1:0] i_start,
    input  pe_pkg::job_t             i_job [pe_pkg::NLANE],
    output logic [pe_pkg::NLANE-1:0] o_done,
    output logic [pe_pkg::NLANE-1:0] o_busy,
    output pe_pkg::acc_t             o_acc [pe_pkg::NLANE]
);
    import pe_pkg::*;

    // ==================================================
    // read port sharing
    // ==================================================
    logic [NLANE-1:0] req;
    logic [NLANE-1:0] gnt;
    logic [AWD-1:0]   lane_addr [NLANE];
    logic             rd_en;
    logic [AWD-1:0]   rd_addr;
    // one read bus, each lane picks its own cycle
    operand_word_t    rd_data;

    operand_ram u_ram (
        .i_clk     (i_clk),
        .i_arst_n  (i_arst_n),
        .i_wr_en   (i_wr_en),
        .i_wr_addr (i_wr_addr),
        .i_wr_data (i_wr_data),
        .i_rd_en   (rd_en),
        .i_rd_addr (rd_addr),
        .o_rd_data (rd_data)
    );

    pe_arbiter u_arb (
        .i_clk     (i_clk),
        .i_arst_n  (i_arst_n),
        .i_req     (req),
        .i_addr    (lane_addr),
        .o_gnt     (gnt),
        .o_rd_en   (rd_en),
        .o_rd_addr (rd_addr)
    );

    // ==================================================
    // compute lanes
    // ==================================================
    for (genvar k = 0; k < NLANE; k++) begin : g_lane
        pe_lane u_lane (
            .i_clk     (i_clk),
            .i_arst_n  (i_arst_n),
            .i_start   (i_start[k]),
            .i_job     (i_job[k]),
            .o_req     (req[k]),
            .o_addr    (lane_addr[k]),
            .i_gnt     (gnt[k]),
            .i_rd_data (rd_data),
            .o_busy    (o_busy[k]),
            .o_done    (o_done[k]),
            .o_acc     (o_acc[k])
        );
    end

endmodule

/* design/pe_lane.sv */
// pe_lane: job sequencer that fetches operand words, runs the dot product, accumulates
`timescale 1ns/1ps

module pe_lane (
    input  logic                   i_clk,
    input  logic                   i_arst_n,
    input  logic                   i_start,
    input  pe_pkg::job_t           i_job,
    output logic                   o_req,
    output logic [pe_pkg::AWD-1:0] o_addr,
    input  logic                   i_gnt,
    input  pe_pkg::operand_word_t  i_rd_data,
    output logic                   o_busy,
    output logic                   o_done,
    output pe_pkg::acc_t           o_acc
);
    import pe_pkg::*;

    // ==================================================
    // job state
    // ==================================================
    au_ctl_t          ctl_q;
    logic             busy_q;
    logic [AWD-1:0]   addr_q;
    // words still to request
    logic [LENWD-1:0] left_q;
    // granted but not yet returned
    logic [1:0]       inflight_q;
    logic             gnt_d_q;
    logic             fin_q;
    logic             done_q;
    acc_t             acc_q;

    logic                      start_ok;
    logic                      last_word;
    logic signed [ASUMDWD-1:0] au_sum;

    // a start on a busy lane is dropped
    assign start_ok  = i_start && !busy_q;
    assign last_word = gnt_d_q && (left_q == '0) && (inflight_q == 2'd1);

    au_mux u_au (
        .i_ctl  (ctl_q),
        .i_ipix (i_rd_data.ipix),
        .i_wpix (i_rd_data.wpix),
        .o_sum  (au_sum)
    );

    always_ff @(posedge i_clk) begin
        if (start_ok) begin
            ctl_q <= i_job.ctl;
        end
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            busy_q     <= 1'b0;
            addr_q     <= '0;
            left_q     <= '0;
            inflight_q <= '0;
            gnt_d_q    <= 1'b0;
            fin_q      <= 1'b0;
            done_q     <= 1'b0;
            acc_q      <= '0;
        end else begin
            gnt_d_q <= i_gnt;
            // last word summed, done follows one cycle later
            fin_q   <= last_word;
            done_q  <= fin_q;
            if (start_ok) begin
                busy_q     <= 1'b1;
                addr_q     <= i_job.base;
                left_q     <= i_job.len;
                inflight_q <= '0;
                acc_q      <= '0;
            end else begin
                // address wraps past 63 by its width
                if (i_gnt) begin
                    addr_q <= addr_q + 1'b1;
                    left_q <= left_q - 1'b1;
                end
                case ({i_gnt, gnt_d_q})
                    2'b10:   inflight_q <= inflight_q + 2'd1;
                    2'b01:   inflight_q <= inflight_q - 2'd1;
                    default: inflight_q <= inflight_q;
                endcase
                // read data is on the bus in the cycle after our grant
                if (gnt_d_q) begin
                    acc_q <= acc_q + au_sum;
                end
                if (fin_q) begin
                    busy_q <= 1'b0;
                end
            end
        end
    end

    assign o_req  = busy_q && (left_q != '0);
    assign o_addr = addr_q;
    assign o_busy = busy_q;
    assign o_done = done_q;
    assign o_acc  = acc_q;

endmodule

/* dv/pe_cluster_tb.sv */
// pe_cluster_tb: table-driven testbench for the MAC cluster with a reference dot-product model
`timescale 1ns/1ps

module pe_cluster_tb;
    import pe_pkg::*;

    localparam int NROW  = 13;
    localparam int NWORD = 2**AWD;

    typedef struct {
        int        lane;
        int        base;
        int        len;
        au_mode_e  mode;
        num_type_e it;
        num_type_e wt;
        bit        conc;
        bit        poke;
        acc_t      exp;
    } row_t;

    logic             clk = 1'b0;
    logic             arst_n;
    logic             wr_en;
    logic [AWD-1:0]   wr_addr;
    operand_word_t    wr_data;
    logic [NLANE-1:0] start;
    job_t             job [NLANE];
    logic [NLANE-1:0] done;
    logic [NLANE-1:0] busy;
    acc_t             acc [NLANE];

    operand_word_t ref_mem [NWORD];
    row_t          rows [NROW];
    int            errors = 0;
    bit            table_ready = 1'b0;

    always #10 clk = ~clk;

    pe_cluster dut0 (
        .i_clk     (clk),
        .i_arst_n  (arst_n),
        .i_wr_en   (wr_en),
        .i_wr_addr (wr_addr),
        .i_wr_data (wr_data),
        .i_start   (start),
        .i_job     (job),
        .o_done    (done),
        .o_busy    (busy),
        .o_acc     (acc)
    );

    // ==================================================
    // reference model
    // ==================================================
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0])
            return (s >> 1) ^ 32'h8020_0003;
        return s >> 1;
    endfunction

    function automatic int elem_val(input logic [DWD-1:0] w, input int i, input int p,
                                    input bit sgn);
        int v;
        v = 0;
        for (int b = 0; b < p; b++) begin
            if (w[i*p + b])
                v += (1 << b);
        end
        // two's complement weight of the top bit
        if (sgn && w[i*p + p - 1])
            v -= (1 << p);
        return v;
    endfunction

    function automatic int ones(input logic [DWD-1:0] w);
        int n;
        n = 0;
        for (int b = 0; b < DWD; b++) begin
            if (w[b])
                n++;
        end
        return n;
    endfunction

    function automatic int word_sum(input row_t r, input logic [DWD-1:0] a,
                                    input logic [DWD-1:0] w);
        int p;
        int s;
        s = 0;
        case (r.mode)
            XNOR: s = 2 * ones(~(a ^ w)) - DWD;
            M1: begin
                s = ones(a & w);
                if (r.it != r.wt)
                    s = -s;
            end
            default: begin
                p = (r.mode == M2) ? 2 : (r.mode == M4) ? 4 : 8;
                for (int i = 0; i < DWD / p; i++) begin
                    s += elem_val(a, i, p, r.it == SIGNED) * elem_val(w, i, p, r.wt == SIGNED);
                end
            end
        endcase
        return s;
    endfunction

    function automatic acc_t model_job(input row_t r);
        acc_t t;
        int   a;
        t = '0;
        for (int j = 0; j < r.len; j++) begin
            a = (r.base + j) % NWORD;
            t = t + acc_t'(word_sum(r, ref_mem[a].ipix, ref_mem[a].wpix));
        end
        return t;
    endfunction

    function automatic job_t make_job(input row_t r);
        job_t j;
        j.base        = AWD'(r.base);
        j.len         = LENWD'(r.len);
        j.ctl.mode    = r.mode;
        j.ctl.i_num_t = r.it;
        j.ctl.w_num_t = r.wt;
        return j;
    endfunction

    // ==================================================
    // compare tasks
    // ==================================================
    task automatic check_acc(input int lane, input acc_t got, input acc_t exp);
        if (got !== exp) begin
            errors++;
            $display("error o_acc[%0d]: got %h expected %h", lane, got, exp);
        end
    endtask

    task automatic check_busy(input int lane, input logic got, input logic exp, input int cyc);
        if (got !== exp) begin
            errors++;
            $display("error o_busy[%0d] cycle %0d: got %h expected %h", lane, cyc, got, exp);
        end
    endtask

    task automatic check_done(input int lane, input logic got, input bit exp, input bit seen,
                              input int cyc);
        if (got === 1'b1 && !exp) begin
            errors++;
            if (seen)
                $display("lane %0d gave a second done pulse at cycle %0d", lane, cyc);
            else
                $display("lane %0d gave a done pulse at cycle %0d when none was due", lane, cyc);
        end else if (got !== 1'b1 && exp) begin
            errors++;
            $display("lane %0d is missing its done pulse at cycle %0d", lane, cyc);
        end
    endtask

    // ==================================================
    // job runners
    // ==================================================
    // cycle n counts rising edges after the start edge
    task automatic run_single(input int r);
        int   ln;
        int   len;
        bit   seen;
        row_t other;
        ln    = rows[r].lane;
        len   = rows[r].len;
        seen  = 1'b0;
        other = '{0, 0, 1, M8, SIGNED, SIGNED, 1'b0, 1'b0, 0};
        @(negedge clk);
        job[ln]   = make_job(rows[r]);
        start[ln] = 1'b1;
        @(negedge clk);
        for (int n = 0; n <= len + 6; n++) begin
            // second start while busy must be dropped
            if (rows[r].poke && n == 2) begin
                job[ln]   = make_job(other);
                start[ln] = 1'b1;
            end else begin
                start[ln] = 1'b0;
            end
            check_busy(ln, busy[ln], n <= len + 1, n);
            check_done(ln, done[ln], n == len + 2, seen, n);
            if (done[ln])
                seen = 1'b1;
            @(negedge clk);
        end
        check_acc(ln, acc[ln], rows[r].exp);
    endtask

    task automatic run_pair(input int r);
        int ln [2];
        int limit;
        bit seen [2];
        ln[0] = rows[r].lane;
        ln[1] = rows[r + 1].lane;
        limit = rows[r].len + rows[r + 1].len + 3;
        seen  = '{1'b0, 1'b0};
        @(negedge clk);
        for (int k = 0; k < 2; k++) begin
            job[ln[k]]   = make_job(rows[r + k]);
            start[ln[k]] = 1'b1;
        end
        @(negedge clk);
        start = '0;
        for (int n = 0; n <= limit + 4; n++) begin
            for (int k = 0; k < 2; k++) begin
                if (done[ln[k]]) begin
                    check_done(ln[k], done[ln[k]], !seen[k] && n <= limit, seen[k], n);
                    seen[k] = 1'b1;
                end
            end
            @(negedge clk);
        end
        for (int k = 0; k < 2; k++) begin
            if (!seen[k])
                check_done(ln[k], done[ln[k]], 1'b1, 1'b0, limit);
            check_acc(ln[k], acc[ln[k]], rows[r + k].exp);
        end
    endtask

    // ==================================================
    // main sequence
    // ==================================================
    initial begin
        logic [31:0] state;
        logic [31:0] word;
        int          r;
        arst_n  = 1'b0;
        wr_en   = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        start   = '0;
        for (int k = 0; k < NLANE; k++)
            job[k] = '0;
        state = 32'h3e85524f;
        for (int a = 0; a < NWORD; a++) begin
            for (int b = 0; b < 32; b++) begin
                state   = lfsr_next(state);
                word[b] = state[0];
            end
            // fixed all-ones and all-zeros words for the binary modes
            if (a == 20)
                word = '1;
            if (a == 21)
                word = '0;
            ref_mem[a] = operand_word_t'(word);
        end
        // lane, base, len, mode, act type, wgt type, concurrent, busy restart
        rows[0]  = '{0,  0,  8, M2,   UNSIGNED, UNSIGNED, 1'b0, 1'b0, 0};
        rows[1]  = '{0,  8,  8, M2,   SIGNED,   SIGNED,   1'b0, 1'b0, 0};
        rows[2]  = '{1, 16,  6, M4,   SIGNED,   UNSIGNED, 1'b0, 1'b0, 0};
        rows[3]  = '{1, 24,  6, M4,   UNSIGNED, SIGNED,   1'b0, 1'b0, 0};
        rows[4]  = '{0, 30,  5, M8,   SIGNED,   SIGNED,   1'b0, 1'b0, 0};
        rows[5]  = '{0, 40,  5, M8,   UNSIGNED, UNSIGNED, 1'b0, 1'b0, 0};
        rows[6]  = '{1, 18,  6, XNOR, UNSIGNED, UNSIGNED, 1'b0, 1'b0, 0};
        rows[7]  = '{0, 19,  4, M1,   SIGNED,   UNSIGNED, 1'b0, 1'b0, 0};
        rows[8]  = '{1, 20,  3, M1,   UNSIGNED, UNSIGNED, 1'b0, 1'b0, 0};
        rows[9]  = '{0,  0, 10, M4,   SIGNED,   SIGNED,   1'b0, 1'b0, 0};
        rows[10] = '{1,  4, 10, M8,   UNSIGNED, SIGNED,   1'b1, 1'b0, 0};
        rows[11] = '{1, 60,  8, M2,   SIGNED,   UNSIGNED, 1'b0, 1'b1, 0};
        rows[12] = '{0, 50, 20, M8,   SIGNED,   UNSIGNED, 1'b0, 1'b0, 0};
        for (int i = 0; i < NROW; i++)
            rows[i].exp = model_job(rows[i]);
        table_ready = 1'b1;

        repeat (2) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        // quiet lanes straight after reset
        for (int n = 0; n < 4; n++) begin
            for (int k = 0; k < NLANE; k++) begin
                check_busy(k, busy[k], 1'b0, n);
                check_done(k, done[k], 1'b0, 1'b0, n);
                check_acc(k, acc[k], '0);
            end
            @(negedge clk);
        end
        for (int a = 0; a < NWORD; a++) begin
            wr_en   = 1'b1;
            wr_addr = AWD'(a);
            wr_data = ref_mem[a];
            @(negedge clk);
        end
        wr_en = 1'b0;

        r = 0;
        while (r < NROW) begin
            if (r + 1 < NROW && rows[r + 1].conc) begin
                run_pair(r);
                r += 2;
            end else begin
                run_single(r);
                r += 1;
            end
        end
        $display("run complete with %0d error(s)", errors);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

    // watchdog sized from the job lengths
    initial begin
        int total;
        wait (table_ready);
        total = 0;
        for (int i = 0; i < NROW; i++)
            total += rows[i].len + 10;
        #(total * 2 * 20);
        $display("timeout after %0d ns, a job never finished", total * 2 * 20);
        $display("Some tests failed");
        $finish;
    end

endmodule

/* run.sh */
#!/bin/sh
# build and run the MAC cluster testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal -f all.f --top-module pe_cluster_tb -o pe_cluster_sim
out=$(./obj_dir/pe_cluster_sim)
echo "$out"
if echo "$out" | grep -q "All tests passed"; then
    exit 0
fi
exit 1
